//--- adam_glue.f
design/adam_pkg.sv
design/core_config.sv
design/sdram_region_arbiter.sv
design/ps2_keypad_emu.sv
design/controller_encoder.sv
design/adam_glue_top.sv
verif/adam_glue_properties.sv
verif/adam_glue_tb.sv

//--- design/adam_glue_top.sv
// console-side glue only; sdram controller and console core sit outside this boundary
`timescale 1ns/100ps

module adam_glue_top import adam_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n_i,

	// menu and reset
	input  logic        mode_i,
	input  logic        swap_i,
	input  logic        reset_btn_i,
	input  logic        reset_menu_i,
	output logic        core_reset_o,

	// image download
	input  logic        ioctl_download_i,
	input  logic        ioctl_wr_i,
	input  dl_addr_t    ioctl_addr_i,
	input  byte_t       ioctl_dout_i,

	// console memory regions
	input  logic        bios_ce_n_i,
	input  logic        eos_ce_n_i,
	input  logic        writer_ce_n_i,
	input  logic        ram_ce_n_i,
	input  logic        lowext_ce_n_i,
	input  logic        hiext_ce_n_i,
	input  bios_addr_t  bios_a_i,
	input  eos_addr_t   eos_a_i,
	input  bank_addr_t  writer_a_i,
	input  bank_addr_t  ram_a_i,
	input  bank_addr_t  lowext_a_i,
	input  bank_addr_t  hiext_a_i,
	input  logic        ram_rd_n_i,
	input  logic        ram_we_n_i,
	input  logic        lowext_rd_n_i,
	input  logic        lowext_we_n_i,
	input  logic        hiext_rd_n_i,
	input  logic        hiext_we_n_i,
	input  byte_t       ram_do_i,
	input  byte_t       lowext_do_i,
	input  byte_t       hiext_do_i,
	output byte_t       bios_d_o,
	output byte_t       eos_d_o,
	output byte_t       writer_d_o,
	output byte_t       ram_d_o,
	output byte_t       lowext_d_o,
	output byte_t       hiext_d_o,
	output cart_page_t  cart_pages_o,

	// sdram port
	input  byte_t       sdram_dout_i,
	output sdram_addr_t sdram_addr_o,
	output logic        sdram_rd_o,
	output logic        sdram_we_o,
	output byte_t       sdram_din_o,

	// controllers
	input  logic        key_strobe_i,
	input  logic        key_pressed_i,
	input  byte_t       key_code_i,
	input  joy_t        joy0_i,
	input  joy_t        joy1_i,
	input  logic [1:0]  ctrl_sel_key_n_i,
	input  logic [1:0]  ctrl_sel_joy_n_i,
	output kp_code_t    ctrl_code_p0_o,
	output kp_code_t    ctrl_code_p1_o,
	output logic [1:0]  ctrl_fire_n_o
);

	logic    swap;
	keypad_t kbd;

	core_config i_core_config (
		.clk_sys          (clk_sys),
		.rst_n_i          (rst_n_i),
		.mode_i           (mode_i),
		.swap_i           (swap_i),
		.reset_btn_i      (reset_btn_i),
		.reset_menu_i     (reset_menu_i),
		.ioctl_download_i (ioctl_download_i),
		.core_reset_o     (core_reset_o),
		.swap_o           (swap)
	);

	sdram_region_arbiter i_sdram_region_arbiter (
		.clk_sys (clk_sys), .rst_n_i (rst_n_i),
		.ioctl_download_i (ioctl_download_i), .ioctl_wr_i (ioctl_wr_i),
		.ioctl_addr_i (ioctl_addr_i), .ioctl_dout_i (ioctl_dout_i),
		.bios_ce_n_i (bios_ce_n_i), .eos_ce_n_i (eos_ce_n_i),
		.writer_ce_n_i (writer_ce_n_i), .ram_ce_n_i (ram_ce_n_i),
		.lowext_ce_n_i (lowext_ce_n_i), .hiext_ce_n_i (hiext_ce_n_i),
		.bios_a_i (bios_a_i), .eos_a_i (eos_a_i), .writer_a_i (writer_a_i),
		.ram_a_i (ram_a_i), .lowext_a_i (lowext_a_i), .hiext_a_i (hiext_a_i),
		.ram_rd_n_i (ram_rd_n_i), .ram_we_n_i (ram_we_n_i),
		.lowext_rd_n_i (lowext_rd_n_i), .lowext_we_n_i (lowext_we_n_i),
		.hiext_rd_n_i (hiext_rd_n_i), .hiext_we_n_i (hiext_we_n_i),
		.ram_do_i (ram_do_i), .lowext_do_i (lowext_do_i), .hiext_do_i (hiext_do_i),
		.sdram_dout_i (sdram_dout_i),
		.sdram_addr_o (sdram_addr_o), .sdram_rd_o (sdram_rd_o),
		.sdram_we_o (sdram_we_o), .sdram_din_o (sdram_din_o),
		.bios_d_o (bios_d_o), .eos_d_o (eos_d_o), .writer_d_o (writer_d_o),
		.ram_d_o (ram_d_o), .lowext_d_o (lowext_d_o), .hiext_d_o (hiext_d_o),
		.cart_pages_o (cart_pages_o)
	);

	ps2_keypad_emu i_ps2_keypad_emu (
		.clk_sys       (clk_sys),
		.rst_n_i       (rst_n_i),
		.key_strobe_i  (key_strobe_i),
		.key_pressed_i (key_pressed_i),
		.key_code_i    (key_code_i),
		.kbd_o         (kbd)
	);

	controller_encoder i_controller_encoder (
		.joy0_i           (joy0_i),
		.joy1_i           (joy1_i),
		.swap_i           (swap),
		.kbd_i            (kbd),
		.ctrl_sel_key_n_i (ctrl_sel_key_n_i),
		.ctrl_sel_joy_n_i (ctrl_sel_joy_n_i),
		.ctrl_code_p0_o   (ctrl_code_p0_o),
		.ctrl_code_p1_o   (ctrl_code_p1_o),
		.ctrl_fire_n_o    (ctrl_fire_n_o)
	);

endmodule

//--- design/adam_pkg.sv
// widths are fixed by the console address map and its two controller ports; no other values work
package adam_pkg;

	// ========================================
	// bus and address widths
	// ========================================
	typedef logic [7:0]  byte_t;
	typedef logic [22:0] sdram_addr_t;
	typedef logic [12:0] bios_addr_t;
	typedef logic [13:0] eos_addr_t;
	typedef logic [14:0] bank_addr_t;
	typedef logic [24:0] dl_addr_t;
	typedef logic [5:0]  cart_page_t;

	// raw joystick word: dirs, fires, star, number, digits 0-9, purple, blue
	typedef logic [19:0] joy_t;
	// scan order: digits, star, number, purple, blue, up, down, left, right, fire 1, fire 2
	typedef logic [19:0] keypad_t;
	typedef logic [3:0]  kp_code_t;

	// ========================================
	// sdram region bases
	// ========================================
	localparam sdram_addr_t BIOS_BASE   = 23'h00000;
	localparam sdram_addr_t EOS_BASE    = 23'h04000;
	localparam sdram_addr_t WRITER_BASE = 23'h08000;
	localparam sdram_addr_t RAM_BASE    = 23'h10000;
	localparam sdram_addr_t LOWEXT_BASE = 23'h18000;
	localparam sdram_addr_t HIEXT_BASE  = 23'h20000;

	// read data seen by a region that is not selected
	localparam byte_t IDLE_BYTE = 8'hFF;

	// ========================================
	// keypad line codes
	// ========================================
	localparam kp_code_t KP_NONE = 4'b1111;

	// indexed by keypad_t bit 0..13
	localparam kp_code_t KP_CODE_TBL [0:13] = '{
		4'b0011, 4'b1110, 4'b1101, 4'b0110, 4'b0001,
		4'b1001, 4'b0111, 4'b1100, 4'b1000, 4'b1011,
		4'b1010, // star
		4'b0101, // number
		4'b0100, // purple
		4'b0010  // blue
	};

endpackage

//--- design/controller_encoder.sv
// purely combinational; keyboard state is shared by both ports
`timescale 1ns/100ps

module controller_encoder import adam_pkg::*; (
	input  joy_t       joy0_i,
	input  joy_t       joy1_i,
	input  logic       swap_i,
	input  keypad_t    kbd_i,
	input  logic [1:0] ctrl_sel_key_n_i,
	input  logic [1:0] ctrl_sel_joy_n_i,
	output kp_code_t   ctrl_code_p0_o,
	output kp_code_t   ctrl_code_p1_o,
	output logic [1:0] ctrl_fire_n_o
);

	// joystick word into scan order
	function automatic keypad_t joy_remap(input joy_t j);
		return {j[5], j[4], j[0], j[1], j[2], j[3],
			j[19], j[18], j[7], j[6], j[17:8]};
	endfunction

	// lowest set key wins
	function automatic kp_code_t key_encode(input keypad_t kp);
		kp_code_t code;
		int       b;
		code = KP_NONE;
		for (b = 13; b >= 0; b--) begin
			if (kp[b])
				code = KP_CODE_TBL[b];
		end
		return code;
	endfunction

	keypad_t  keypad [2];
	kp_code_t port_code [2];

	assign keypad[0] = joy_remap(swap_i ? joy1_i : joy0_i) | kbd_i;
	assign keypad[1] = joy_remap(swap_i ? joy0_i : joy1_i) | kbd_i;

	// ========================================
	// per-port scan
	// ========================================
	for (genvar p = 0; p < 2; p++) begin : g_port
		kp_code_t key_half;
		kp_code_t joy_half;
		logic     key_fire_n;
		logic     joy_fire_n;

		always_comb begin
			key_half   = KP_NONE;
			key_fire_n = 1'b1;
			if (!ctrl_sel_key_n_i[p]) begin
				key_half   = key_encode(keypad[p]);
				key_fire_n = ~keypad[p][19];
			end
		end

		// up, down, left, right on lines 3..0
		always_comb begin
			joy_half   = KP_NONE;
			joy_fire_n = 1'b1;
			if (!ctrl_sel_joy_n_i[p]) begin
				joy_half   = ~{keypad[p][14], keypad[p][15], keypad[p][16], keypad[p][17]};
				joy_fire_n = ~keypad[p][18];
			end
		end

		assign port_code[p]     = key_half & joy_half;
		assign ctrl_fire_n_o[p] = key_fire_n & joy_fire_n;
	end

	assign ctrl_code_p0_o = port_code[0];
	assign ctrl_code_p1_o = port_code[1];

endmodule

//--- design/core_config.sv
// mode change gives one cycle of core reset, one cycle late; other reset sources pass through combinationally
`timescale 1ns/100ps

module core_config (
	input  logic clk_sys,
	input  logic rst_n_i,
	input  logic mode_i,
	input  logic swap_i,
	input  logic reset_btn_i,
	input  logic reset_menu_i,
	input  logic ioctl_download_i,
	output logic core_reset_o,
	output logic swap_o
);

	logic mode_q;
	logic mode_chg_q;
	logic swap_q;

	// mode copy tracks the input even in reset, so release gives no pulse
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			mode_q     <= mode_i;
			mode_chg_q <= 1'b0;
			swap_q     <= 1'b0;
		end else begin
			mode_q     <= mode_i;
			mode_chg_q <= (mode_i != mode_q);
			swap_q     <= swap_i;
		end
	end

	// all reset sources into one console reset
	assign core_reset_o = ~rst_n_i | reset_btn_i | reset_menu_i |
		ioctl_download_i | mode_chg_q;

	assign swap_o = swap_q;

endmodule

//--- design/ps2_keypad_emu.sv
// set 2 make/break codes only; extended prefix is ignored so main row and keypad share digits
`timescale 1ns/100ps

module ps2_keypad_emu import adam_pkg::*; (
	input  logic    clk_sys,
	input  logic    rst_n_i,
	input  logic    key_strobe_i,
	input  logic    key_pressed_i,
	input  byte_t   key_code_i,
	output keypad_t kbd_o
);

	logic [9:0] btn_digit;
	logic       btn_star;
	logic       btn_minus;
	logic       btn_shift;

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			btn_digit <= '0;
			btn_star  <= 1'b0;
			btn_minus <= 1'b0;
			btn_shift <= 1'b0;
		end else if (key_strobe_i) begin
			case (key_code_i)
				// main row
				8'h45: btn_digit[0] <= key_pressed_i;
				8'h16: btn_digit[1] <= key_pressed_i;
				8'h1E: btn_digit[2] <= key_pressed_i;
				8'h26: btn_digit[3] <= key_pressed_i;
				8'h25: btn_digit[4] <= key_pressed_i;
				8'h2E: btn_digit[5] <= key_pressed_i;
				8'h36: btn_digit[6] <= key_pressed_i;
				8'h3D: btn_digit[7] <= key_pressed_i;
				8'h3E: btn_digit[8] <= key_pressed_i;
				8'h46: btn_digit[9] <= key_pressed_i;
				// numeric pad
				8'h70: btn_digit[0] <= key_pressed_i;
				8'h69: btn_digit[1] <= key_pressed_i;
				8'h72: btn_digit[2] <= key_pressed_i;
				8'h7A: btn_digit[3] <= key_pressed_i;
				8'h6B: btn_digit[4] <= key_pressed_i;
				8'h73: btn_digit[5] <= key_pressed_i;
				8'h74: btn_digit[6] <= key_pressed_i;
				8'h6C: btn_digit[7] <= key_pressed_i;
				8'h75: btn_digit[8] <= key_pressed_i;
				8'h7D: btn_digit[9] <= key_pressed_i;
				8'h7C: btn_star     <= key_pressed_i;
				8'h7B: btn_minus    <= key_pressed_i;
				// either shift
				8'h12, 8'h59: btn_shift <= key_pressed_i;
				default: ;
			endcase
		end
	end

	// shift+8 is star and shift+3 is number, as on a pc keyboard
	assign kbd_o = {8'b0,
		btn_minus | (btn_shift & btn_digit[3]),
		btn_star  | (btn_shift & btn_digit[8]),
		btn_digit};

endmodule

//--- design/sdram_region_arbiter.sv
// no back-pressure; the sdram side must finish each access within one console clock enable
`timescale 1ns/100ps

module sdram_region_arbiter import adam_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n_i,

	input  logic        ioctl_download_i,
	input  logic        ioctl_wr_i,
	input  dl_addr_t    ioctl_addr_i,
	input  byte_t       ioctl_dout_i,

	input  logic        bios_ce_n_i,
	input  logic        eos_ce_n_i,
	input  logic        writer_ce_n_i,
	input  logic        ram_ce_n_i,
	input  logic        lowext_ce_n_i,
	input  logic        hiext_ce_n_i,

	input  bios_addr_t  bios_a_i,
	input  eos_addr_t   eos_a_i,
	input  bank_addr_t  writer_a_i,
	input  bank_addr_t  ram_a_i,
	input  bank_addr_t  lowext_a_i,
	input  bank_addr_t  hiext_a_i,

	input  logic        ram_rd_n_i,
	input  logic        ram_we_n_i,
	input  logic        lowext_rd_n_i,
	input  logic        lowext_we_n_i,
	input  logic        hiext_rd_n_i,
	input  logic        hiext_we_n_i,

	input  byte_t       ram_do_i,
	input  byte_t       lowext_do_i,
	input  byte_t       hiext_do_i,

	input  byte_t       sdram_dout_i,

	output sdram_addr_t sdram_addr_o,
	output logic        sdram_rd_o,
	output logic        sdram_we_o,
	output byte_t       sdram_din_o,

	output byte_t       bios_d_o,
	output byte_t       eos_d_o,
	output byte_t       writer_d_o,
	output byte_t       ram_d_o,
	output byte_t       lowext_d_o,
	output byte_t       hiext_d_o,

	output cart_page_t  cart_pages_o
);

	// ========================================
	// address map
	// ========================================
	always_comb begin
		if (ioctl_download_i)
			sdram_addr_o = ioctl_addr_i[22:0];
		else if (!bios_ce_n_i)
			sdram_addr_o = BIOS_BASE + sdram_addr_t'(bios_a_i);
		else if (!eos_ce_n_i)
			sdram_addr_o = EOS_BASE + sdram_addr_t'(eos_a_i);
		else if (!writer_ce_n_i)
			sdram_addr_o = WRITER_BASE + sdram_addr_t'(writer_a_i);
		else if (!ram_ce_n_i)
			sdram_addr_o = RAM_BASE + sdram_addr_t'(ram_a_i);
		else if (!lowext_ce_n_i)
			sdram_addr_o = LOWEXT_BASE + sdram_addr_t'(lowext_a_i);
		else if (!hiext_ce_n_i)
			sdram_addr_o = HIEXT_BASE + sdram_addr_t'(hiext_a_i);
		else
			sdram_addr_o = RAM_BASE + sdram_addr_t'(ram_a_i);
	end

	// roms read on chip enable alone, rams need their strobe too
	assign sdram_rd_o = ~bios_ce_n_i | ~eos_ce_n_i | ~writer_ce_n_i |
		(~ram_ce_n_i & ~ram_rd_n_i) | (~lowext_ce_n_i & ~lowext_rd_n_i) |
		(~hiext_ce_n_i & ~hiext_rd_n_i);

	assign sdram_we_o = ioctl_wr_i | (~ram_ce_n_i & ~ram_we_n_i) |
		(~lowext_ce_n_i & ~lowext_we_n_i) | (~hiext_ce_n_i & ~hiext_we_n_i);

	// write data priority
	assign sdram_din_o = ioctl_wr_i    ? ioctl_dout_i :
		!ram_we_n_i    ? ram_do_i :
		!hiext_we_n_i  ? hiext_do_i :
		!lowext_we_n_i ? lowext_do_i : 8'h00;

	// ========================================
	// read steering
	// ========================================
	assign bios_d_o   = bios_ce_n_i   ? IDLE_BYTE : sdram_dout_i;
	assign eos_d_o    = eos_ce_n_i    ? IDLE_BYTE : sdram_dout_i;
	assign writer_d_o = writer_ce_n_i ? IDLE_BYTE : sdram_dout_i;
	assign ram_d_o    = ram_rd_n_i    ? IDLE_BYTE : sdram_dout_i;
	assign lowext_d_o = lowext_rd_n_i ? IDLE_BYTE : sdram_dout_i;
	assign hiext_d_o  = hiext_rd_n_i  ? IDLE_BYTE : sdram_dout_i;

	// cartridge size follows the last download write address
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i)
			cart_pages_o <= '0;
		else if (ioctl_wr_i)
			cart_pages_o <= ioctl_addr_i[19:14];
	end

endmodule

//--- verif/adam_glue_properties.sv
// bound into adam_glue_top; sampled on the rising clk_sys edge, inputs must settle before it
`timescale 1ns/100ps

module adam_glue_properties import adam_pkg::*; (
	input logic        clk_sys,
	input logic        rst_n_i,
	input logic        mode_i,
	input logic        reset_btn_i,
	input logic        reset_menu_i,
	input logic        core_reset_o,
	input logic        ioctl_download_i,
	input logic        ioctl_wr_i,
	input dl_addr_t    ioctl_addr_i,
	input logic        bios_ce_n_i, eos_ce_n_i, writer_ce_n_i,
	input logic        ram_ce_n_i, lowext_ce_n_i, hiext_ce_n_i,
	input logic        ram_rd_n_i, lowext_rd_n_i, hiext_rd_n_i,
	input byte_t       sdram_dout_i,
	input byte_t       bios_d_o, eos_d_o, writer_d_o,
	input byte_t       ram_d_o, lowext_d_o, hiext_d_o,
	input sdram_addr_t sdram_addr_o,
	input logic        sdram_rd_o,
	input logic        sdram_we_o,
	input cart_page_t  cart_pages_o
);

	int unsigned fail_count = 0;
	logic        all_ce_idle;

	task automatic note_failure(input string what);
		fail_count++;
		$error("CHECK FAILED at %0t: %s", $time, what);
	endtask

	// a region that is not selected reads all ones
	function automatic byte_t region_read(input logic sel_n, input byte_t dout);
		return sel_n ? 8'hFF : dout;
	endfunction

	assign all_ce_idle = bios_ce_n_i & eos_ce_n_i & writer_ce_n_i &
		ram_ce_n_i & lowext_ce_n_i & hiext_ce_n_i;

	// ========================================
	// core reset
	// ========================================
	// mode pulse lands one cycle after the change, and never right after reset
	a_core_reset: assert property (@(posedge clk_sys)
		core_reset_o == (!rst_n_i || reset_btn_i || reset_menu_i || ioctl_download_i ||
			($past(rst_n_i) && ($past(mode_i) != $past(mode_i, 2)))))
		else note_failure("core reset sources");

	// ========================================
	// download path
	// ========================================
	a_dl_addr: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		ioctl_download_i |-> sdram_addr_o == ioctl_addr_i[22:0])
		else note_failure("download address");

	a_dl_we: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		(ioctl_download_i && ram_ce_n_i && lowext_ce_n_i && hiext_ce_n_i) |->
			sdram_we_o == ioctl_wr_i)
		else note_failure("download write strobe");

	a_cart_pages: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		ioctl_wr_i |=> cart_pages_o == $past(ioctl_addr_i[19:14]))
		else note_failure("cartridge pages");

	// read steering, roms by chip enable and rams by read strobe
	a_rom_read: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		{bios_d_o, eos_d_o, writer_d_o} == {region_read(bios_ce_n_i, sdram_dout_i),
			region_read(eos_ce_n_i, sdram_dout_i), region_read(writer_ce_n_i, sdram_dout_i)})
		else note_failure("rom read steering");

	a_ram_read: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		{ram_d_o, lowext_d_o, hiext_d_o} == {region_read(ram_rd_n_i, sdram_dout_i),
			region_read(lowext_rd_n_i, sdram_dout_i), region_read(hiext_rd_n_i, sdram_dout_i)})
		else note_failure("ram read steering");

	a_idle_strobes: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		(all_ce_idle && !ioctl_wr_i) |-> (!sdram_rd_o && !sdram_we_o))
		else note_failure("strobes while idle");

endmodule

bind adam_glue_top adam_glue_properties i_adam_glue_properties (.*);

//--- verif/adam_glue_tb.sv
// inputs change on the falling edge only; region addresses and data come from a seeded $urandom
`timescale 1ns/100ps

module adam_glue_tb import adam_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 2000;

	// console memory map
	localparam sdram_addr_t REGION_BASE [0:5] = '{
		23'h00000, 23'h04000, 23'h08000, 23'h10000, 23'h18000, 23'h20000
	};

	logic        clk_sys;
	logic        rst_n_i;
	logic        mode_i, swap_i, reset_btn_i, reset_menu_i, core_reset_o;
	logic        ioctl_download_i, ioctl_wr_i;
	dl_addr_t    ioctl_addr_i;
	byte_t       ioctl_dout_i;
	logic        bios_ce_n_i, eos_ce_n_i, writer_ce_n_i;
	logic        ram_ce_n_i, lowext_ce_n_i, hiext_ce_n_i;
	bios_addr_t  bios_a_i;
	eos_addr_t   eos_a_i;
	bank_addr_t  writer_a_i, ram_a_i, lowext_a_i, hiext_a_i;
	logic        ram_rd_n_i, ram_we_n_i, lowext_rd_n_i, lowext_we_n_i;
	logic        hiext_rd_n_i, hiext_we_n_i;
	byte_t       ram_do_i, lowext_do_i, hiext_do_i;
	byte_t       bios_d_o, eos_d_o, writer_d_o, ram_d_o, lowext_d_o, hiext_d_o;
	cart_page_t  cart_pages_o;
	byte_t       sdram_dout_i, sdram_din_o;
	sdram_addr_t sdram_addr_o;
	logic        sdram_rd_o, sdram_we_o;
	logic        key_strobe_i, key_pressed_i;
	byte_t       key_code_i;
	joy_t        joy0_i, joy1_i;
	logic [1:0]  ctrl_sel_key_n_i, ctrl_sel_joy_n_i, ctrl_fire_n_o;
	kp_code_t    ctrl_code_p0_o, ctrl_code_p1_o;

	int unsigned check_errs = 0;
	int unsigned other_errs = 0;
	int unsigned cycle_cnt = 0;
	bank_addr_t  local_a [6];

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	adam_glue_top i_adam_glue_top (.*);

	task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp)
		else begin
			check_errs++;
			$display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic set_idle();
		{bios_ce_n_i, eos_ce_n_i, writer_ce_n_i} = 3'b111;
		{ram_ce_n_i, lowext_ce_n_i, hiext_ce_n_i} = 3'b111;
		{ram_rd_n_i, lowext_rd_n_i, hiext_rd_n_i} = 3'b111;
		{ram_we_n_i, lowext_we_n_i, hiext_we_n_i} = 3'b111;
		ioctl_download_i = 1'b0;
		ioctl_wr_i       = 1'b0;
	endtask

	// en bit order is bios, eos, writer, ram, lowext, hiext
	task automatic drive_regions(input logic [5:0] en);
		int k;
		local_a[0] = bank_addr_t'($urandom) & 15'h1FFF;
		local_a[1] = bank_addr_t'($urandom) & 15'h3FFF;
		for (k = 2; k < 6; k++)
			local_a[k] = bank_addr_t'($urandom);
		bios_a_i   = local_a[0][12:0];
		eos_a_i    = local_a[1][13:0];
		writer_a_i = local_a[2];
		ram_a_i    = local_a[3];
		lowext_a_i = local_a[4];
		hiext_a_i  = local_a[5];
		{hiext_ce_n_i, lowext_ce_n_i, ram_ce_n_i, writer_ce_n_i, eos_ce_n_i, bios_ce_n_i} = ~en;
		{hiext_rd_n_i, lowext_rd_n_i, ram_rd_n_i} = ~en[5:3];
		sdram_dout_i = byte_t'($urandom);
	endtask

	// one strobe cycle, then wait past the latch edge
	task automatic key_event(input logic pressed, input byte_t code);
		@(negedge clk_sys);
		key_strobe_i  = 1'b1;
		key_pressed_i = pressed;
		key_code_i    = code;
		@(negedge clk_sys);
		key_strobe_i = 1'b0;
		#20;
	endtask

	task automatic report_and_finish();
		int unsigned prop_errs;
		prop_errs = i_adam_glue_top.i_adam_glue_properties.fail_count;
		$display("errors: checks %0d, properties %0d, other %0d",
			check_errs, prop_errs, other_errs);
		if (check_errs + prop_errs + other_errs == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	endtask

	// ========================================
	// watchdog
	// ========================================
	initial begin
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycle_cnt++;
		end
		other_errs++;
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		report_and_finish();
	end

	// ========================================
	// stimulus
	// ========================================
	initial begin
		int          i;
		int          j;
		byte_t       exp_din;
		dl_addr_t    dl_a;
		sdram_addr_t exp_addr;

		void'($urandom(32'he385_3522));
		rst_n_i = 1'b0;
		{mode_i, swap_i, reset_btn_i, reset_menu_i} = 4'b0000;
		set_idle();
		ioctl_addr_i = '0;
		ioctl_dout_i = '0;
		drive_regions(6'b000000);
		{ram_do_i, lowext_do_i, hiext_do_i} = '0;
		{key_strobe_i, key_pressed_i} = 2'b00;
		key_code_i = '0;
		joy0_i = '0;
		joy1_i = '0;
		ctrl_sel_key_n_i = 2'b11;
		ctrl_sel_joy_n_i = 2'b11;
		#20;
		check_val(core_reset_o, 1'b1, "core reset during reset");
		repeat (10) @(negedge clk_sys);
		rst_n_i = 1'b1;

		// every region alone and every pair, lower index wins
		for (i = 0; i < 6; i++) begin
			for (j = i; j < 6; j++) begin
				@(negedge clk_sys);
				drive_regions(6'(1 << i) | 6'(1 << j));
				#20;
				exp_addr = REGION_BASE[i] + sdram_addr_t'(local_a[i]);
				check_val(sdram_addr_o, exp_addr, "region address");
				check_val(sdram_rd_o, 1'b1, "read strobe");
			end
		end
		@(negedge clk_sys);
		drive_regions(6'b000000);
		#20;
		check_val(sdram_addr_o, 23'h10000 + sdram_addr_t'(ram_a_i), "default ram mapping");

		// one ram writes at a time
		for (i = 3; i < 6; i++) begin
			@(negedge clk_sys);
			set_idle();
			ram_do_i    = byte_t'($urandom);
			lowext_do_i = byte_t'($urandom);
			hiext_do_i  = byte_t'($urandom);
			ram_ce_n_i    = (i != 3);
			ram_we_n_i    = (i != 3);
			lowext_ce_n_i = (i != 4);
			lowext_we_n_i = (i != 4);
			hiext_ce_n_i  = (i != 5);
			hiext_we_n_i  = (i != 5);
			#20;
			exp_din = (i == 3) ? ram_do_i : (i == 4) ? lowext_do_i : hiext_do_i;
			check_val(sdram_din_o, exp_din, "ram write data");
			check_val({sdram_we_o, sdram_rd_o}, 2'b10, "ram write strobes");
		end

		@(negedge clk_sys);
		set_idle();
		ioctl_download_i = 1'b1;
		for (i = 0; i < 4; i++) begin
			@(negedge clk_sys);
			dl_a = dl_addr_t'($urandom);
			ioctl_addr_i = dl_a;
			ioctl_dout_i = byte_t'($urandom);
			ioctl_wr_i   = 1'b1;
			#20;
			check_val(sdram_addr_o, dl_a[22:0], "download address");
			check_val(sdram_din_o, ioctl_dout_i, "download data");
			check_val(core_reset_o, 1'b1, "core reset during download");
			@(negedge clk_sys);
			ioctl_wr_i = 1'b0;
			#20;
			check_val(cart_pages_o, dl_a[19:14], "cartridge pages");
		end
		@(negedge clk_sys);
		ioctl_download_i = 1'b0;

		// keypad through port 0 key select
		ctrl_sel_key_n_i = 2'b10;
		key_event(1'b1, 8'h2E);
		check_val(ctrl_code_p0_o, 4'b1001, "digit 5 key");
		check_val(ctrl_code_p1_o, 4'b1111, "port 1 unselected");
		key_event(1'b0, 8'h2E);
		check_val(ctrl_code_p0_o, 4'b1111, "digit 5 released");
		key_event(1'b1, 8'h12);
		key_event(1'b1, 8'h3E);
		check_val(i_adam_glue_top.kbd[10], 1'b1, "shift with 8 sets star");
		// digit 8 sits below star in the scan order
		check_val(ctrl_code_p0_o, 4'b1000, "shift with 8 code");
		key_event(1'b0, 8'h3E);
		key_event(1'b0, 8'h12);
		key_event(1'b1, 8'h7C);
		check_val(ctrl_code_p0_o, 4'b1010, "star key");
		key_event(1'b0, 8'h7C);

		// joystick half of port 0
		@(negedge clk_sys);
		ctrl_sel_key_n_i = 2'b11;
		ctrl_sel_joy_n_i = 2'b10;
		joy0_i = 20'h00008;
		#20;
		check_val(ctrl_code_p0_o, 4'b0111, "joystick up");
		@(negedge clk_sys);
		joy0_i = 20'h00018;
		#20;
		check_val(ctrl_fire_n_o, 2'b10, "fire 1");
		@(negedge clk_sys);
		ctrl_sel_key_n_i = 2'b10;
		ctrl_sel_joy_n_i = 2'b11;
		joy0_i = 20'h80000;
		#20;
		check_val(ctrl_code_p0_o, 4'b0010, "blue button");

		// swap moves joy0 to port 1 one cycle later
		@(negedge clk_sys);
		ctrl_sel_key_n_i = 2'b11;
		ctrl_sel_joy_n_i = 2'b00;
		joy0_i = 20'h00008;
		@(negedge clk_sys);
		swap_i = 1'b1;
		#20;
		check_val({ctrl_code_p0_o, ctrl_code_p1_o}, 8'h7F, "swap not yet taken");
		@(negedge clk_sys);
		#20;
		check_val({ctrl_code_p0_o, ctrl_code_p1_o}, 8'hF7, "swapped ports");
		@(negedge clk_sys);
		swap_i = 1'b0;
		joy0_i = '0;
		ctrl_sel_joy_n_i = 2'b11;

		// core reset sources
		@(negedge clk_sys);
		reset_btn_i = 1'b1;
		#20;
		check_val(core_reset_o, 1'b1, "reset button");
		@(negedge clk_sys);
		reset_btn_i = 1'b0;
		#20;
		check_val(core_reset_o, 1'b0, "reset button released");
		@(negedge clk_sys);
		reset_menu_i = 1'b1;
		#20;
		check_val(core_reset_o, 1'b1, "reset menu bit");
		@(negedge clk_sys);
		reset_menu_i = 1'b0;
		#20;
		check_val(core_reset_o, 1'b0, "reset menu bit cleared");
		@(negedge clk_sys);
		mode_i = ~mode_i;
		#20;
		check_val(core_reset_o, 1'b0, "mode not yet registered");
		@(negedge clk_sys);
		#20;
		check_val(core_reset_o, 1'b1, "mode change pulse");
		@(negedge clk_sys);
		#20;
		check_val(core_reset_o, 1'b0, "mode pulse length");

		repeat (3) @(negedge clk_sys);
		report_and_finish();
	end

endmodule
